// ==== sim.f ====
logic/sound_pkg.sv
logic/phase_gen.sv
logic/tone_counter.sv
logic/tone_irq.sv
logic/dac_out.sv
logic/upd1771c_sound.sv
verif/tb_upd1771c_sound.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_upd1771c_sound \
  -Mdir obj_dir \
  -f sim.f

output=$(./obj_dir/Vtb_upd1771c_sound || true)
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

// ==== verif/tb_upd1771c_sound.sv ====
`default_nettype none

module tb_upd1771c_sound;

  import sound_pkg::*;

  localparam int clk_half      = 4;
  localparam int clk_period    = 2 * clk_half;
  localparam int reset_cycles  = 8;
  localparam int wrap_cycles   = 256 * step_div;  // NC runs down from 0 after reset
  localparam int no_irq_window = 2000;

  logic              CLK = 1'b0;
  logic              reset;
  logic              cken;
  logic              wr;
  logic [sel_w-1:0]  wr_sel;
  logic [data_w-1:0] wr_data;
  logic              reti;
  logic              irq;
  logic [vec_w-1:0]  irq_vec;
  logic [pcm_w-1:0]  pcm_out;

  int cycle_cnt;
  int seed;
  int max_period;
  int fail_count;
  bit table_ready;

  ////////////////////
  // stimulus table

  string             name_q[$];
  logic [data_w-1:0] n_q[$];
  logic [data_w-1:0] mode_q[$];
  logic [data_w-1:0] sign_q[$];
  logic [data_w-1:0] sample_q[$];
  logic [vec_w-1:0]  vec_q[$];
  int                period_q[$];  // CLK cycles, 0 for silent
  logic [pcm_w-1:0]  pcm_q[$];

  upd1771c_sound u_dut (
    .CLK     (CLK),
    .reset   (reset),
    .cken    (cken),
    .wr      (wr),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .reti    (reti),
    .irq     (irq),
    .irq_vec (irq_vec),
    .pcm_out (pcm_out)
  );

  always #clk_half CLK = ~CLK;

  ////////////////////
  // helpers

  task automatic fail_run(input string why);
    fail_count++;
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      fail_run($sformatf("Error %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  // inputs change and outputs are read 1 unit after the edge
  task automatic next_cycle;
    @(posedge CLK);
    #1;
    cycle_cnt++;
  endtask

  task automatic apply_reset;
    reset = 1'b1;
    wr    = 1'b0;
    reti  = 1'b0;
    repeat (reset_cycles) next_cycle();
    reset = 1'b0;
  endtask

  task automatic host_write(input logic [sel_w-1:0] sel, input logic [data_w-1:0] data);
    wr      = 1'b1;
    wr_sel  = sel;
    wr_data = data;
    next_cycle();
    wr      = 1'b0;
  endtask

  task automatic wait_irq(input string name, input int limit, output int seen_at);
    int waited;
    waited  = 0;
    seen_at = -1;
    while (seen_at < 0) begin
      next_cycle();
      waited++;
      if (irq) begin
        seen_at = cycle_cnt;
      end else if (waited >= limit) begin
        fail_run($sformatf("no irq came within %0d cycles in entry %s", limit, name));
      end
    end
  endtask

  // reti taken on the third edge after irq
  task automatic send_reti;
    repeat (2) next_cycle();
    reti = 1'b1;
    next_cycle();
    reti = 1'b0;
  endtask

  task automatic watch_silence(input string name, input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      next_cycle();
      if (irq) begin
        fail_run($sformatf("irq fired in entry %s where none was expected", name));
      end
    end
  endtask

  // PCM word from the sign flags and the sample byte
  function automatic logic [pcm_w-1:0] expected_pcm(input logic [data_w-1:0] sign,
                                                    input logic [data_w-1:0] d);
    logic ts;
    logic ss;
    ts = sign[sign_ts_bit];
    ss = sign[sign_ss_bit];
    case ({ts, ss})
      2'b00:   return {1'b0, d};
      2'b10:   return {1'b0, ~d};
      2'b11:   return {1'b1, ~d};
      default: return {1'b1, d};  // ss only
    endcase
  endfunction

  task automatic add_entry(input string name, input logic [data_w-1:0] n,
                           input logic [data_w-1:0] mode, input logic [data_w-1:0] sign,
                           input logic [data_w-1:0] sample, input logic [vec_w-1:0] vec,
                           input int period, input logic [pcm_w-1:0] pcm);
    name_q.push_back(name);
    n_q.push_back(n);
    mode_q.push_back(mode);
    sign_q.push_back(sign);
    sample_q.push_back(sample);
    vec_q.push_back(vec);
    period_q.push_back(period);
    pcm_q.push_back(pcm);
  endtask

  task automatic build_table;
    logic [data_w-1:0] rnd;
    int i;
    // mode 02 sets tone_ie, sign bit 7 is ts and bit 6 is ss
    add_entry("n40_plain", 8'h40, 8'h02, 8'h00, 8'h5a, 12'h02c, 512, 9'h05a);  // 8N
    add_entry("nff_inv", 8'hff, 8'h02, 8'h80, 8'h3c, 12'h02c, 2040, 9'h0c3);
    add_entry("n41_plain", 8'h41, 8'h02, 8'h00, 8'h80, 12'h02c, 520, 9'h080);
    add_entry("n20_neg_inv", 8'h20, 8'h02, 8'hc0, 8'h81, 12'h028, 512, 9'h17e);  // 16N
    add_entry("n3f_neg", 8'h3f, 8'h02, 8'h40, 8'h12, 12'h028, 1008, 9'h112);
    rnd = 8'($random(seed));
    add_entry("n10_rand", 8'h10, 8'h02, 8'h00, rnd, 12'h024, 512, expected_pcm(8'h00, rnd));
    rnd = 8'($random(seed));
    add_entry("n1f_rand", 8'h1f, 8'h02, 8'h80, rnd, 12'h024, 992, expected_pcm(8'h80, rnd));
    rnd = 8'($random(seed));
    add_entry("n08_rand", 8'h08, 8'h02, 8'hc0, rnd, 12'h020, 512, expected_pcm(8'hc0, rnd));
    add_entry("n0f_neg", 8'h0f, 8'h02, 8'h40, 8'hff, 12'h020, 960, 9'h1ff);  // 64N
    add_entry("n07_silent", 8'h07, 8'h02, 8'hc0, 8'ha5, 12'h000, 0, 9'h15a);
    add_entry("ie_off", 8'h40, 8'h00, 8'h80, 8'h0f, 12'h000, 0, 9'h0f0);
    max_period = 0;
    for (i = 0; i < period_q.size(); i++) begin
      if (period_q[i] > max_period) begin
        max_period = period_q[i];
      end
    end
  endtask

  ////////////////////
  // one table entry

  task automatic run_entry(input int idx);
    string name;
    int    t0;
    int    t1;
    name = name_q[idx];
    apply_reset();
    check_value({name, " reset irq"}, 0, int'(irq));
    check_value({name, " reset pcm"}, 0, int'(pcm_out));
    host_write(sel_mode, mode_q[idx]);
    host_write(sel_n, n_q[idx]);
    host_write(sel_sign, sign_q[idx]);
    host_write(sel_sample, sample_q[idx]);
    check_value({name, " pcm"}, int'(pcm_q[idx]), int'(pcm_out));  // one cycle after write
    if (period_q[idx] == 0) begin
      watch_silence(name, wrap_cycles + no_irq_window);
    end else begin
      wait_irq(name, wrap_cycles + 2 * max_period, t0);
      send_reti();
      wait_irq(name, 2 * max_period, t1);
      check_value({name, " period"}, period_q[idx], t1 - t0);
      check_value({name, " vector"}, int'(vec_q[idx]), int'(irq_vec));
      send_reti();
    end
  endtask

  initial begin
    reset       = 1'b1;
    cken        = 1'b1;
    wr          = 1'b0;
    wr_sel      = '0;
    wr_data     = '0;
    reti        = 1'b0;
    cycle_cnt   = 0;
    fail_count  = 0;
    seed        = 53215;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    for (int i = 0; i < name_q.size(); i++) begin
      run_entry(i);
    end
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // budget per entry covers reset, NC wrap, two periods and the silent window
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = name_q.size() *
            (reset_cycles + 8 + wrap_cycles + 3 * max_period + no_irq_window + 200);
    #(limit * clk_period);
    fail_run($sformatf("watchdog expired after %0d cycles", limit));
  end

endmodule

`default_nettype wire

// ==== logic/upd1771c_sound.sv ====
`default_nettype none

module upd1771c_sound (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        cken,
  input  logic                        wr,
  input  logic [sound_pkg::sel_w-1:0]  wr_sel,
  input  logic [sound_pkg::data_w-1:0] wr_data,
  input  logic                        reti,
  output logic                        irq,
  output logic [sound_pkg::vec_w-1:0]  irq_vec,
  output logic [sound_pkg::pcm_w-1:0]  pcm_out
);

  logic       step;       // machine step strobe
  logic       tone_trig;
  logic [3:0] n_range;    // band of N, one-hot

  ////////////////////
  // clock generator

  phase_gen u_phase_gen (
    .CLK   (CLK),
    .reset (reset),
    .cken  (cken),
    .step  (step)
  );

  ////////////////////
  // tone section

  tone_counter u_tone_counter (
    .CLK       (CLK),
    .reset     (reset),
    .step      (step),
    .wr        (wr),
    .wr_sel    (wr_sel),
    .wr_data   (wr_data),
    .n_range   (n_range),
    .tone_trig (tone_trig)
  );

  tone_irq u_tone_irq (
    .CLK       (CLK),
    .reset     (reset),
    .step      (step),
    .wr        (wr),
    .wr_sel    (wr_sel),
    .wr_data   (wr_data),
    .tone_trig (tone_trig),
    .n_range   (n_range),
    .reti      (reti),
    .irq       (irq),
    .irq_vec   (irq_vec)
  );

  ////////////////////
  // DAC output

  dac_out u_dac_out (
    .CLK     (CLK),
    .reset   (reset),
    .wr      (wr),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .pcm_out (pcm_out)
  );

endmodule

`default_nettype wire

// ==== logic/dac_out.sv ====
`default_nettype none

module dac_out (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        wr,
  input  logic [sound_pkg::sel_w-1:0]  wr_sel,
  input  logic [sound_pkg::data_w-1:0] wr_data,
  output logic [sound_pkg::pcm_w-1:0]  pcm_out
);

  import sound_pkg::*;

  logic              ts;         // tone sign
  logic              ss;         // sample sign, DAC negative
  logic [data_w+1:0] da;         // {invert, negative, sample}
  logic [data_w-1:0] mag;
  logic              pcm_neg;

  ////////////////////
  // sign flags and DA latch

  always_ff @(posedge CLK) begin
    if (reset) begin
      ts <= 1'b0;
      ss <= 1'b0;
    end else if (wr && (wr_sel == sel_sign)) begin
      ts <= wr_data[sign_ts_bit];
      ss <= wr_data[sign_ss_bit];
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      da <= '0;
    end else if (wr && (wr_sel == sel_sample)) begin
      da <= {ss ^ ts, ss, wr_data};
    end
  end

  ////////////////////
  // PCM conversion

  // top DA bit flips the byte before the DAC
  assign mag     = da[data_w+1] ? ~da[data_w-1:0] : da[data_w-1:0];
  assign pcm_neg = da[data_w];

  // sign bit above the byte, lower bits inverted when negative
  assign pcm_out = {pcm_neg, pcm_neg ? ~mag : mag};

endmodule

`default_nettype wire

// ==== logic/tone_irq.sv ====
`default_nettype none

module tone_irq (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        step,
  input  logic                        wr,
  input  logic [sound_pkg::sel_w-1:0]  wr_sel,
  input  logic [sound_pkg::data_w-1:0] wr_data,
  input  logic                        tone_trig,
  input  logic [3:0]                  n_range,
  input  logic                        reti,
  output logic                        irq,
  output logic [sound_pkg::vec_w-1:0]  irq_vec
);

  import sound_pkg::*;

  logic             tone_ie;     // mode bit
  logic             pending;
  logic             active;
  logic             set_active;
  logic [vec_w-1:0] vec_ofs;

  ////////////////////
  // mode register

  always_ff @(posedge CLK) begin
    if (reset) begin
      tone_ie <= 1'b0;
    end else if (wr && (wr_sel == sel_mode)) begin
      tone_ie <= wr_data[mode_tone_ie_bit];
    end
  end

  ////////////////////
  // pending / active

  // pending is promoted at the next step boundary
  assign set_active = step & pending & tone_ie & ~active;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (set_active) begin
      pending <= 1'b0;
    end else if (tone_trig && tone_ie && !active) begin
      pending <= 1'b1;  // dropped while active
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      active <= 1'b0;
      irq    <= 1'b0;
    end else begin
      irq <= set_active;  // one cycle, same edge as active
      if (set_active) begin
        active <= 1'b1;
      end else if (reti) begin
        active <= 1'b0;
      end
    end
  end

  ////////////////////
  // vector

  always_comb begin
    vec_ofs = '0;  // 08..0F sits on the base
    if (n_range[1]) begin
      vec_ofs = vec_ofs_10;
    end else if (n_range[2]) begin
      vec_ofs = vec_ofs_20;
    end else if (n_range[3]) begin
      vec_ofs = vec_ofs_40;
    end
  end

  always_ff @(posedge CLK) begin
    if (set_active) begin
      irq_vec <= vec_tone_base + vec_ofs;  // held until next irq
    end
  end

  a_irq_enabled : assert property (
    @(posedge CLK) disable iff (reset)
    irq |-> $past(tone_ie)
  );

  a_irq_not_nested : assert property (
    @(posedge CLK) disable iff (reset)
    irq |-> !$past(active)
  );

endmodule

`default_nettype wire

// ==== logic/tone_counter.sv ====
`default_nettype none

module tone_counter (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        step,
  input  logic                        wr,
  input  logic [sound_pkg::sel_w-1:0]  wr_sel,
  input  logic [sound_pkg::data_w-1:0] wr_data,
  output logic [3:0]                  n_range,
  output logic                        tone_trig
);

  import sound_pkg::*;

  logic [data_w-1:0] n;          // reload value
  logic [data_w-1:0] nc;         // down counter
  logic [nuc_w-1:0]  nuc;        // counts NC reloads
  logic              nc_eq_01;
  logic              reload_d;   // reload seen on the previous step
  logic              tone_cond;
  logic              tone_cond_d;

  ////////////////////
  // N register

  always_ff @(posedge CLK) begin
    if (wr && (wr_sel == sel_n)) begin
      n <= wr_data;
    end
  end

  ////////////////////
  // NC and NUC

  assign nc_eq_01 = (nc == data_w'(1));

  always_ff @(posedge CLK) begin
    if (reset) begin
      nc <= '0;
    end else if (step) begin
      if (nc_eq_01) begin
        nc <= n;  // reload
      end else begin
        nc <= nc - 1'b1;
      end
    end
  end

  // nuc bumps one step after each reload
  always_ff @(posedge CLK) begin
    if (reset) begin
      reload_d <= 1'b0;
      nuc      <= '0;
    end else if (step) begin
      reload_d <= nc_eq_01;
      if (reload_d) begin
        nuc <= nuc + 1'b1;
      end
    end
  end

  ////////////////////
  // range and trigger

  assign n_range[0] = (n >= n_lim_08) && (n < n_lim_10);
  assign n_range[1] = (n >= n_lim_10) && (n < n_lim_20);
  assign n_range[2] = (n >= n_lim_20) && (n < n_lim_40);
  assign n_range[3] = (n >= n_lim_40);

  // short N uses higher nuc bits, so the period stays roughly even
  always_comb begin
    if (n_range[3]) begin
      tone_cond = reload_d;
    end else if (n_range[2]) begin
      tone_cond = nuc[0];
    end else if (n_range[1]) begin
      tone_cond = nuc[1];
    end else if (n_range[0]) begin
      tone_cond = nuc[2];
    end else begin
      tone_cond = 1'b0;  // N below 08, silent
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      tone_cond_d <= 1'b0;
    end else if (step) begin
      tone_cond_d <= tone_cond;
    end
  end

  // falling edge of the condition, seen on a step
  assign tone_trig = step & (|n_range) & tone_cond_d & ~tone_cond;

  a_range_onehot : assert property (
    @(posedge CLK) disable iff (reset)
    $onehot0(n_range)
  );

endmodule

`default_nettype wire

// ==== logic/phase_gen.sv ====
`default_nettype none

module phase_gen (
  input  logic CLK,
  input  logic reset,
  input  logic cken,
  output logic step
);

  import sound_pkg::*;

  ////////////////////
  // cycle counter

  logic [$clog2(step_div)-1:0] cyc_cnt;  // position inside the step

  always_ff @(posedge CLK) begin
    if (reset) begin
      cyc_cnt <= '0;
    end else if (cken) begin
      cyc_cnt <= cyc_cnt + 1'b1;  // wraps every step_div enables
    end
  end

  // last state of the cycle, same slot as the cp1p phase
  assign step = cken & (&cyc_cnt);

endmodule

`default_nettype wire

// ==== logic/sound_pkg.sv ====
`default_nettype none

package sound_pkg;

  ////////////////////
  // host write port

  localparam int sel_w  = 2;
  localparam int data_w = 8;

  localparam logic [sel_w-1:0] sel_n      = 2'd0;  // tone reload value N
  localparam logic [sel_w-1:0] sel_mode   = 2'd1;  // mode register
  localparam logic [sel_w-1:0] sel_sign   = 2'd2;  // ts / ss flags
  localparam logic [sel_w-1:0] sel_sample = 2'd3;  // DAC sample byte

  localparam int mode_tone_ie_bit = 1;  // tone interrupt enable
  localparam int sign_ts_bit      = 7;  // tone sign
  localparam int sign_ss_bit      = 6;  // sample sign

  ////////////////////
  // timing and counters

  localparam int step_div = 8;  // enabled clocks per machine step
  localparam int nuc_w    = 3;  // reload counter width

  // band limits of N
  localparam logic [data_w-1:0] n_lim_08 = 8'h08;
  localparam logic [data_w-1:0] n_lim_10 = 8'h10;
  localparam logic [data_w-1:0] n_lim_20 = 8'h20;
  localparam logic [data_w-1:0] n_lim_40 = 8'h40;

  ////////////////////
  // interrupt vector

  localparam int vec_w = 12;

  localparam logic [vec_w-1:0] vec_tone_base = 12'h020;
  localparam logic [vec_w-1:0] vec_ofs_10    = 12'h004;  // N in 10..1F
  localparam logic [vec_w-1:0] vec_ofs_20    = 12'h008;  // N in 20..3F
  localparam logic [vec_w-1:0] vec_ofs_40    = 12'h00c;  // N in 40..FF

  ////////////////////
  // DAC

  localparam int pcm_w = 9;  // sign plus 8 bit magnitude

endpackage

`default_nettype wire
